// ==== logic/except_settings.svh ====
// Widths, reset values and debug stop bit positions of the exception unit, included by its RTL
`ifndef EXCEPT_SETTINGS_SVH
`define EXCEPT_SETTINGS_SVH

`define EXC_ADDR_W      32        // pc and data address width
`define EXC_SR_W        16        // status register and esr width
`define EXC_DSR_W       14        // debug stop register width
`define EXC_NUM_SRC     12        // number of exception requests

`define EXC_ESR_RESET   16'h8001  // esr after reset, supervisor mode set
`define EXC_SR_IEE_BIT  2         // interrupt enable in sr
`define EXC_IEE_DELAY   3         // depth of the iee delay line

// debug stop bit per request, bus error is shared by both sides
`define EXC_DSR_BUSERR  1
`define EXC_DSR_DPF     2
`define EXC_DSR_IPF     3
`define EXC_DSR_ALIGN   5
`define EXC_DSR_ILLEGAL 6
`define EXC_DSR_INT     7
`define EXC_DSR_DTLB    8
`define EXC_DSR_ITLB    9
`define EXC_DSR_RANGE   10
`define EXC_DSR_SYSCALL 11
`define EXC_DSR_TRAP    13

`endif

// ==== logic/except_pkg.sv ====
// Types shared by the exception unit modules, imported by each of them and by the testbench
`default_nettype none
`include "except_settings.svh"

package except_pkg;

  typedef logic [`EXC_ADDR_W-1:0]  addr_t;    // pc or data address
  typedef logic [`EXC_SR_W-1:0]    sr_t;      // status register contents
  typedef logic [`EXC_DSR_W-1:0]   dsr_t;     // debug stop register
  typedef logic [`EXC_NUM_SRC-1:0] src_vec_t; // one bit per request, msb wins

  // request positions in src_vec_t
  localparam int unsigned SRC_INT     = 11;
  localparam int unsigned SRC_ITLB    = 10;
  localparam int unsigned SRC_IMMU    = 9;
  localparam int unsigned SRC_IBUS    = 8;
  localparam int unsigned SRC_ILLEGAL = 7;
  localparam int unsigned SRC_ALIGN   = 6;
  localparam int unsigned SRC_DTLB    = 5;
  localparam int unsigned SRC_DMMU    = 4;
  localparam int unsigned SRC_DBUS    = 3;
  localparam int unsigned SRC_RANGE   = 2;
  localparam int unsigned SRC_TRAP    = 1;
  localparam int unsigned SRC_SYSCALL = 0;

  // instruction-side flag positions carried down the pipe
  localparam int unsigned IFLAG_IBUS = 2;
  localparam int unsigned IFLAG_ITLB = 1;
  localparam int unsigned IFLAG_IMMU = 0;

  typedef enum logic [3:0] {
    EXC_NONE    = 4'h0,
    EXC_BUSERR  = 4'h2,
    EXC_DPF     = 4'h3,
    EXC_IPF     = 4'h4,
    EXC_ALIGN   = 4'h6,
    EXC_ILLEGAL = 4'h7,
    EXC_INT     = 4'h8,
    EXC_DTLB    = 4'h9,
    EXC_ITLB    = 4'ha,
    EXC_RANGE   = 4'hb,
    EXC_SYSCALL = 4'hc,
    EXC_TRAP    = 4'he
  } exc_type_e;

  typedef enum logic [2:0] {
    IDLE, WAIT_FETCH, DRAIN1, DRAIN2, RESTART
  } flush_state_e;

  typedef struct packed {
    logic ibuserr;   // instruction bus error
    logic itlbmiss;  // instruction tlb miss
    logic immufault; // instruction mmu page fault
    logic dbuserr;   // data bus error
    logic dmmufault; // data mmu page fault
    logic dtlbmiss;  // data tlb miss
    logic align;     // misaligned access
    logic illegal;   // illegal instruction
    logic range;     // range exception
  } fault_sig_t;

  typedef struct packed {
    addr_t id_pc;
    addr_t ex_pc;
    addr_t wb_pc;
    logic  ex_dslot; // ex instruction sits in a delay slot
  } pipe_pcs_t;

  typedef struct packed {
    addr_t data;     // spr write data from the core
    logic  epcr_we;
    logic  eear_we;
    logic  esr_we;
  } spr_wr_t;

endpackage

`default_nettype wire

// ==== logic/except_pc_pipe.sv ====
// PC and instruction fault flag pipeline from decode to writeback, feeding the exception select
`default_nettype none

module except_pc_pipe (
  input  wire                   clk,
  input  wire                   rst,
  input  except_pkg::addr_t     if_pc_i,
  input  wire                   id_freeze_i,
  input  wire                   ex_freeze_i,
  input  wire                   wb_freeze_i,
  input  wire                   branch_taken_i,
  input  wire                   flushpipe_i,
  input  except_pkg::fault_sig_t faults_i,
  output except_pkg::pipe_pcs_t pcs_o,
  output logic [2:0]            ex_iflags_o
);
  import except_pkg::*;

  addr_t      id_pc;
  addr_t      ex_pc;
  addr_t      wb_pc;
  logic [2:0] id_flags; // {ibuserr, itlbmiss, immufault} of the id instruction
  logic [2:0] ex_flags;
  logic       ex_dslot;

  // decode stage
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      id_pc    <= '0;
      id_flags <= '0;
    end
    else if (flushpipe_i)
    begin
      id_pc    <= '0;           // squashed slot
      id_flags <= '0;
    end
    else if (!id_freeze_i)
    begin
      id_pc    <= if_pc_i;
      id_flags <= {faults_i.ibuserr, faults_i.itlbmiss, faults_i.immufault};
    end
  end

  // execute stage
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      ex_pc    <= '0;
      ex_flags <= '0;
      ex_dslot <= 1'b0;
    end
    else if (flushpipe_i)
    begin
      ex_pc    <= '0;
      ex_flags <= '0;
      ex_dslot <= 1'b0;
    end
    else if (!ex_freeze_i)
    begin
      ex_pc <= id_pc;
      if (id_freeze_i)
      begin
        ex_flags <= '0;         // bubble behind a stalled decode
        ex_dslot <= 1'b0;
      end
      else
      begin
        ex_flags <= id_flags;
        ex_dslot <= branch_taken_i; // instruction after a taken branch
      end
    end
  end

  // writeback stage, not cleared by a flush
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      wb_pc <= '0;
    else if (!wb_freeze_i)
      wb_pc <= ex_pc;
  end

  assign pcs_o.id_pc    = id_pc;
  assign pcs_o.ex_pc    = ex_pc;
  assign pcs_o.wb_pc    = wb_pc;
  assign pcs_o.ex_dslot = ex_dslot;
  assign ex_iflags_o    = ex_flags;

endmodule

`default_nettype wire

// ==== logic/except_detect.sv ====
// Exception request gathering with interrupt enable delay and debug stop masking
`default_nettype none
`include "except_settings.svh"

module except_detect (
  input  wire                    clk,
  input  wire                    rst,
  input  except_pkg::fault_sig_t faults_i,
  input  wire                    int_i,
  input  wire                    trap_i,
  input  wire                    syscall_i,
  input  except_pkg::sr_t        sr_i,
  input  wire                    sr_we_i,
  input  except_pkg::dsr_t       dsr_i,
  input  wire                    ex_freeze_i,
  input  wire                    branch_taken_i,
  input  wire                    ex_dslot_i,
  input  wire [2:0]              ex_iflags_i,
  output except_pkg::src_vec_t   trig_o,
  output logic                   abort_ex_o,
  output except_pkg::src_vec_t   except_stop_o
);
  import except_pkg::*;

  logic [`EXC_IEE_DELAY-1:0] iee_dly; // ones shift in while iee stays set
  logic                      int_pending;
  src_vec_t                  req;     // raw requests before debug masking
  src_vec_t                  dsr_mask;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      iee_dly <= '0;
    else if (!sr_i[`EXC_SR_IEE_BIT])
      iee_dly <= '0;                  // restart the wait on every disable
    else
      iee_dly <= {iee_dly[`EXC_IEE_DELAY-2:0], 1'b1};
  end

  // no interrupt while ex is held, on a branch, in a delay slot or during an sr update
  assign int_pending = int_i & sr_i[`EXC_SR_IEE_BIT] & iee_dly[`EXC_IEE_DELAY-1] &
                       ~ex_freeze_i & ~branch_taken_i & ~ex_dslot_i & ~sr_we_i;

  always_comb
  begin
    req[SRC_INT]     = int_pending;
    req[SRC_ITLB]    = ex_iflags_i[IFLAG_ITLB];
    req[SRC_IMMU]    = ex_iflags_i[IFLAG_IMMU];
    req[SRC_IBUS]    = ex_iflags_i[IFLAG_IBUS];
    req[SRC_ILLEGAL] = faults_i.illegal;
    req[SRC_ALIGN]   = faults_i.align;
    req[SRC_DTLB]    = faults_i.dtlbmiss;
    req[SRC_DMMU]    = faults_i.dmmufault;
    req[SRC_DBUS]    = faults_i.dbuserr;
    req[SRC_RANGE]   = faults_i.range;
    req[SRC_TRAP]    = trap_i & ~ex_freeze_i;    // only once the instruction leaves ex
    req[SRC_SYSCALL] = syscall_i & ~ex_freeze_i;
  end

  always_comb
  begin
    dsr_mask[SRC_INT]     = dsr_i[`EXC_DSR_INT];
    dsr_mask[SRC_ITLB]    = dsr_i[`EXC_DSR_ITLB];
    dsr_mask[SRC_IMMU]    = dsr_i[`EXC_DSR_IPF];
    dsr_mask[SRC_IBUS]    = dsr_i[`EXC_DSR_BUSERR]; // shared with the data side
    dsr_mask[SRC_ILLEGAL] = dsr_i[`EXC_DSR_ILLEGAL];
    dsr_mask[SRC_ALIGN]   = dsr_i[`EXC_DSR_ALIGN];
    dsr_mask[SRC_DTLB]    = dsr_i[`EXC_DSR_DTLB];
    dsr_mask[SRC_DMMU]    = dsr_i[`EXC_DSR_DPF];
    dsr_mask[SRC_DBUS]    = dsr_i[`EXC_DSR_BUSERR];
    dsr_mask[SRC_RANGE]   = dsr_i[`EXC_DSR_RANGE];
    dsr_mask[SRC_TRAP]    = dsr_i[`EXC_DSR_TRAP];
    dsr_mask[SRC_SYSCALL] = dsr_i[`EXC_DSR_SYSCALL];
  end

  assign trig_o        = req & ~dsr_mask; // handled as exceptions
  assign except_stop_o = req & dsr_mask;  // handed to the debug unit instead

  // kill the ex instruction on data-side faults and illegal opcodes
  assign abort_ex_o = faults_i.dbuserr | faults_i.dmmufault | faults_i.dtlbmiss |
                      faults_i.align | faults_i.illegal;

endmodule

`default_nettype wire

// ==== logic/except_select.sv ====
// Priority encoder picking the winning exception and its EPCR and EEAR values
`default_nettype none

module except_select (
  input  except_pkg::src_vec_t  trig_i,
  input  except_pkg::pipe_pcs_t pcs_i,
  input  except_pkg::addr_t     lsu_addr_i,
  output except_pkg::exc_type_e type_o,
  output except_pkg::addr_t     epcr_o,
  output except_pkg::addr_t     eear_o,
  output logic                  eear_load_o
);
  import except_pkg::*;

  addr_t id_slot_pc; // restart at id unless the fault sits in a delay slot
  addr_t ex_slot_pc; // restart at ex unless the fault sits in a delay slot

  assign id_slot_pc = pcs_i.ex_dslot ? pcs_i.wb_pc : pcs_i.id_pc;
  assign ex_slot_pc = pcs_i.ex_dslot ? pcs_i.wb_pc : pcs_i.ex_pc;

  always_comb
  begin
    type_o      = EXC_NONE;
    epcr_o      = ex_slot_pc;  // most requests restart the ex instruction
    eear_o      = lsu_addr_i;
    eear_load_o = 1'b0;
    if (trig_i[SRC_INT])
    begin
      type_o = EXC_INT;
      epcr_o = id_slot_pc;
    end
    else if (trig_i[SRC_ITLB])
    begin
      type_o      = EXC_ITLB;
      eear_o      = pcs_i.ex_pc;
      eear_load_o = 1'b1;
    end
    else if (trig_i[SRC_IMMU])
    begin
      type_o      = EXC_IPF;
      epcr_o      = id_slot_pc;
      eear_o      = pcs_i.ex_dslot ? pcs_i.ex_pc : pcs_i.id_pc;
      eear_load_o = 1'b1;
    end
    else if (trig_i[SRC_IBUS])
    begin
      type_o      = EXC_BUSERR;
      eear_o      = ex_slot_pc;
      eear_load_o = 1'b1;
    end
    else if (trig_i[SRC_ILLEGAL])
    begin
      type_o      = EXC_ILLEGAL;
      eear_o      = pcs_i.ex_pc;
      eear_load_o = 1'b1;
    end
    else if (trig_i[SRC_ALIGN])
    begin
      type_o      = EXC_ALIGN;
      eear_load_o = 1'b1;      // faulting data address
    end
    else if (trig_i[SRC_DTLB])
    begin
      type_o      = EXC_DTLB;
      eear_load_o = 1'b1;
    end
    else if (trig_i[SRC_DMMU])
    begin
      type_o      = EXC_DPF;
      eear_load_o = 1'b1;
    end
    else if (trig_i[SRC_DBUS])
    begin
      type_o      = EXC_BUSERR; // same vector as the instruction side
      eear_load_o = 1'b1;
    end
    else if (trig_i[SRC_RANGE])
    begin
      type_o = EXC_RANGE;
      epcr_o = id_slot_pc;
    end
    else if (trig_i[SRC_TRAP])
      type_o = EXC_TRAP;
    else if (trig_i[SRC_SYSCALL])
    begin
      type_o = EXC_SYSCALL;
      epcr_o = id_slot_pc;     // return past the syscall
    end
  end

endmodule

`default_nettype wire

// ==== logic/except_ctrl.sv ====
// Flush state machine and exception SPRs with software write access
`default_nettype none
`include "except_settings.svh"

module except_ctrl (
  input  wire                   clk,
  input  wire                   rst,
  input  except_pkg::src_vec_t  trig_i,
  input  except_pkg::exc_type_e type_i,
  input  except_pkg::addr_t     epcr_i,
  input  except_pkg::addr_t     eear_i,
  input  wire                   eear_load_i,
  input  wire                   pc_we_i,
  input  except_pkg::sr_t       sr_i,
  input  except_pkg::sr_t       to_sr_i,
  input  wire                   sr_we_i,
  input  except_pkg::spr_wr_t   spr_wr_i,
  input  wire                   icpu_ack_i,
  input  wire                   icpu_err_i,
  input  wire                   genpc_freeze_i,
  input  wire                   if_stall_i,
  input  wire                   id_freeze_i,
  output logic                  flushpipe_o,
  output logic                  extend_flush_o,
  output except_pkg::exc_type_e except_type_o,
  output logic                  except_start_o,
  output logic                  except_started_o,
  output except_pkg::addr_t     epcr_o,
  output except_pkg::addr_t     eear_o,
  output except_pkg::sr_t       esr_o
);
  import except_pkg::*;

  flush_state_e state;
  exc_type_e    type_q;
  logic         extend_flush;
  logic         except_flushpipe; // new exception accepted this cycle
  addr_t        epcr_q;
  addr_t        eear_q;
  sr_t          esr_q;

  assign except_flushpipe = (|trig_i) & (state == IDLE);
  assign flushpipe_o      = except_flushpipe | pc_we_i | extend_flush;
  assign except_start_o   = (type_q != EXC_NONE) & extend_flush;
  assign except_started_o = extend_flush & except_start_o;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state        <= IDLE;
      type_q       <= EXC_NONE;
      extend_flush <= 1'b0;
      epcr_q       <= '0;
      eear_q       <= '0;
      esr_q        <= `EXC_ESR_RESET;
    end
    else
    begin
      case (state)
        IDLE:
        begin
          if (except_flushpipe)
          begin
            state        <= WAIT_FETCH;
            extend_flush <= 1'b1;
            type_q       <= type_i;
            epcr_q       <= epcr_i;
            esr_q        <= sr_we_i ? to_sr_i : sr_i; // sr as it would be after ex
            if (eear_load_i)
              eear_q <= eear_i;
          end
          else if (pc_we_i)
          begin
            state        <= WAIT_FETCH; // pc write refetches without a vector
            extend_flush <= 1'b1;
          end
          else
          begin
            if (spr_wr_i.epcr_we)
              epcr_q <= spr_wr_i.data;
            if (spr_wr_i.eear_we)
              eear_q <= spr_wr_i.data;
            if (spr_wr_i.esr_we)
              esr_q <= {1'b1, spr_wr_i.data[`EXC_SR_W-2:0]}; // sm bit stays set
          end
        end
        WAIT_FETCH:
        begin
          if (icpu_ack_i | icpu_err_i | genpc_freeze_i)
            state <= DRAIN1;            // handler fetch answered
        end
        DRAIN1:
        begin
          if (type_q == EXC_TRAP)
          begin
            state        <= IDLE;       // trap goes straight back
            extend_flush <= 1'b0;
            type_q       <= EXC_NONE;
          end
          else
            state <= DRAIN2;
        end
        DRAIN2:
        begin
          state        <= RESTART;
          extend_flush <= 1'b0;
        end
        RESTART:
        begin
          if (!if_stall_i && !id_freeze_i)
          begin
            state  <= IDLE;
            type_q <= EXC_NONE;
          end
        end
        default:
          state <= IDLE;
      endcase
    end
  end

  assign extend_flush_o = extend_flush;
  assign except_type_o  = type_q;
  assign epcr_o         = epcr_q;
  assign eear_o         = eear_q;
  assign esr_o          = esr_q;

endmodule

`default_nettype wire

// ==== logic/except_top.sv ====
// Exception unit top level connecting the PC pipe, request detector, selector and flush control
`default_nettype none

module except_top (
  input  wire                    clk,
  input  wire                    rst,
  input  except_pkg::addr_t      if_pc_i,
  input  wire                    id_freeze_i,
  input  wire                    ex_freeze_i,
  input  wire                    wb_freeze_i,
  input  wire                    if_stall_i,
  input  wire                    genpc_freeze_i,
  input  wire                    branch_taken_i,
  input  except_pkg::fault_sig_t faults_i,
  input  wire                    int_i,
  input  wire                    trap_i,
  input  wire                    syscall_i,
  input  except_pkg::sr_t        sr_i,
  input  except_pkg::sr_t        to_sr_i,
  input  wire                    sr_we_i,
  input  except_pkg::dsr_t       du_dsr_i,
  input  except_pkg::addr_t      lsu_addr_i,
  input  wire                    pc_we_i,
  input  except_pkg::spr_wr_t    spr_wr_i,
  input  wire                    icpu_ack_i,
  input  wire                    icpu_err_i,
  output logic                   flushpipe_o,
  output logic                   extend_flush_o,
  output except_pkg::exc_type_e  except_type_o,
  output logic                   except_start_o,
  output logic                   except_started_o,
  output except_pkg::src_vec_t   except_stop_o,
  output logic                   abort_ex_o,
  output except_pkg::addr_t      epcr_o,
  output except_pkg::addr_t      eear_o,
  output except_pkg::sr_t        esr_o
);
  import except_pkg::*;

  pipe_pcs_t  pcs;       // stage pcs and delay slot marker
  logic [2:0] ex_iflags;
  src_vec_t   trig;
  exc_type_e  sel_type;
  addr_t      sel_epcr;
  addr_t      sel_eear;
  logic       sel_eear_load;

  except_pc_pipe u_pc_pipe (
    .clk, .rst, .if_pc_i, .id_freeze_i, .ex_freeze_i, .wb_freeze_i, .branch_taken_i,
    .flushpipe_i (flushpipe_o), .faults_i, .pcs_o (pcs), .ex_iflags_o (ex_iflags)
  );

  except_detect u_detect (
    .clk, .rst, .faults_i, .int_i, .trap_i, .syscall_i, .sr_i, .sr_we_i,
    .dsr_i (du_dsr_i), .ex_freeze_i, .branch_taken_i, .ex_dslot_i (pcs.ex_dslot),
    .ex_iflags_i (ex_iflags), .trig_o (trig), .abort_ex_o, .except_stop_o
  );

  except_select u_select (
    .trig_i (trig), .pcs_i (pcs), .lsu_addr_i, .type_o (sel_type),
    .epcr_o (sel_epcr), .eear_o (sel_eear), .eear_load_o (sel_eear_load)
  );

  except_ctrl u_ctrl (
    .clk, .rst, .trig_i (trig), .type_i (sel_type), .epcr_i (sel_epcr),
    .eear_i (sel_eear), .eear_load_i (sel_eear_load), .pc_we_i, .sr_i, .to_sr_i,
    .sr_we_i, .spr_wr_i, .icpu_ack_i, .icpu_err_i, .genpc_freeze_i, .if_stall_i,
    .id_freeze_i, .flushpipe_o, .extend_flush_o, .except_type_o, .except_start_o,
    .except_started_o, .epcr_o, .eear_o, .esr_o
  );

endmodule

`default_nettype wire

// ==== tests/except_checker.sv ====
// Concurrent assertions on the exception unit outputs that the testbench binds into except_top
`default_nettype none

module except_checker (
  input wire                   clk,
  input wire                   rst,
  input wire                   flushpipe_i,
  input wire                   extend_flush_i,
  input except_pkg::exc_type_e except_type_i,
  input wire                   except_start_i,
  input except_pkg::addr_t     epcr_i,
  input except_pkg::addr_t     eear_i,
  input except_pkg::sr_t       esr_i
);
  import except_pkg::*;

  int fail_count; // read by the testbench at the end

  initial
    fail_count = 0;

  // outputs idle during reset and on the first edge after it
  reset_values_a: assert property (@(posedge clk) (rst || $past(rst)) |->
    (!flushpipe_i && !except_start_i && except_type_i == EXC_NONE && epcr_i == '0 &&
     eear_i == '0 && esr_i == 16'h8001))
    else
    begin
      $error("outputs not at reset values");
      fail_count = fail_count + 1;
    end

  // a new flush from idle is held by extend_flush on the next edge
  accept_a: assert property (@(posedge clk) disable iff (rst)
    (flushpipe_i && !extend_flush_i) |=> extend_flush_i)
    else
    begin
      $error("flush request not followed by extend_flush");
      fail_count = fail_count + 1;
    end

  // only a trap clears its type as extend_flush drops
  flush_end_a: assert property (@(posedge clk) disable iff (rst)
    ($fell(extend_flush_i) && $past(except_type_i) != EXC_NONE) |->
    ((except_type_i == EXC_NONE) == ($past(except_type_i) == EXC_TRAP)))
    else
    begin
      $error("vector type wrong at the end of the flush");
      fail_count = fail_count + 1;
    end

endmodule

`default_nettype wire

// ==== tests/except_tb.sv ====
// Exception unit testbench driving except_top through reset, SPR, priority, debug and flush tests
`default_nettype none

module except_tb;
  import except_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int NUM_TESTS  = 6;
  localparam int WATCHDOG   = 40 * CLK_PERIOD * NUM_TESTS; // 40 cycles per test

  logic       clk;
  logic       rst;
  addr_t      if_pc;
  logic       id_freeze;
  logic       ex_freeze;
  logic       wb_freeze;
  logic       if_stall;
  logic       genpc_freeze;
  logic       branch_taken;
  fault_sig_t faults;
  logic       int_req;
  logic       trap;
  logic       syscall;
  sr_t        sr;
  sr_t        to_sr;
  logic       sr_we;
  dsr_t       du_dsr;
  addr_t      lsu_addr;
  logic       pc_we;
  spr_wr_t    spr_wr;
  logic       icpu_ack;
  logic       icpu_err;
  logic       flushpipe;
  logic       extend_flush;
  exc_type_e  except_type;
  logic       except_start;
  logic       except_started;
  src_vec_t   except_stop;
  logic       abort_ex;
  addr_t      epcr;
  addr_t      eear;
  sr_t        esr;

  integer     seed;
  int         error_count;
  int         check_count;
  int         test_count;
  int         test_start_errors;
  int         total_errors;
  int         i;
  int         n;
  int         trap_cycles;
  logic [31:0] r;
  logic [31:0] r2;
  addr_t      data;
  exc_type_e  exp_type;
  addr_t      exp_epcr;
  addr_t      exp_eear;
  sr_t        exp_esr;
  logic       data_fault;
  addr_t      mdl_id;  // tracked decode pc
  addr_t      mdl_ex;  // tracked execute pc

  except_top UUT (
    .clk, .rst, .if_pc_i (if_pc), .id_freeze_i (id_freeze), .ex_freeze_i (ex_freeze),
    .wb_freeze_i (wb_freeze), .if_stall_i (if_stall), .genpc_freeze_i (genpc_freeze),
    .branch_taken_i (branch_taken), .faults_i (faults), .int_i (int_req), .trap_i (trap),
    .syscall_i (syscall), .sr_i (sr), .to_sr_i (to_sr), .sr_we_i (sr_we),
    .du_dsr_i (du_dsr), .lsu_addr_i (lsu_addr), .pc_we_i (pc_we), .spr_wr_i (spr_wr),
    .icpu_ack_i (icpu_ack), .icpu_err_i (icpu_err), .flushpipe_o (flushpipe),
    .extend_flush_o (extend_flush), .except_type_o (except_type),
    .except_start_o (except_start), .except_started_o (except_started),
    .except_stop_o (except_stop), .abort_ex_o (abort_ex), .epcr_o (epcr), .eear_o (eear),
    .esr_o (esr)
  );

  bind except_top except_checker u_checker (
    .clk (clk), .rst (rst), .flushpipe_i (flushpipe_o), .extend_flush_i (extend_flush_o),
    .except_type_i (except_type_o), .except_start_i (except_start_o), .epcr_i (epcr_o),
    .eear_i (eear_o), .esr_i (esr_o)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // stage pcs as the core sees them with all freezes low
  always @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      mdl_id <= '0;
      mdl_ex <= '0;
    end
    else if (flushpipe)
    begin
      mdl_id <= '0;               // flush squashes decode and execute
      mdl_ex <= '0;
    end
    else
    begin
      mdl_id <= if_pc;
      mdl_ex <= mdl_id;
    end
  end

  task automatic next_cycle();
    @(posedge clk);
    #10;                          // inputs change just after the edge
    if_pc = if_pc + 32'd4;
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    assert (got === exp)
    else
    begin
      $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic wait_idle(input int max_cycles);
    int k;
    k = 0;
    while ((extend_flush || except_type != EXC_NONE) && k < max_cycles)
    begin
      next_cycle();
      k++;
    end
    check_count++;
    assert (!extend_flush && except_type == EXC_NONE)
    else
    begin
      $display("flush sequence still running after %0d cycles", max_cycles);
      error_count++;
    end
  endtask

  task automatic report_test(input string name);
    test_count++;
    $display("test %0d %s done with %0d errors", test_count, name,
             error_count - test_start_errors);
    test_start_errors = error_count;
  endtask

  // masks the request raised by the caller with one dsr bit
  task automatic expect_debug_stop(input dsr_t dsr, input src_vec_t exp_stop);
    du_dsr = dsr;
    #5;
    check_value("except_stop_o", {20'h0, except_stop}, {20'h0, exp_stop});
    check_value("flushpipe_o", {31'h0, flushpipe}, 32'h0);
    next_cycle();
    faults = '0;
    trap   = 1'b0;
    du_dsr = '0;
    check_value("except_type_o", {28'h0, except_type}, {28'h0, EXC_NONE});
  endtask

  initial
  begin
    seed              = 46;
    error_count       = 0;
    check_count       = 0;
    test_count        = 0;
    test_start_errors = 0;
    exp_eear          = '0;
    clk          = 1'b0;
    rst          = 1'b1;
    if_pc        = 32'h0000_1000;
    id_freeze    = 1'b0;
    ex_freeze    = 1'b0;
    wb_freeze    = 1'b0;
    if_stall     = 1'b0;
    genpc_freeze = 1'b0;
    branch_taken = 1'b0;
    faults       = '0;
    int_req      = 1'b0;
    trap         = 1'b0;
    syscall      = 1'b0;
    sr           = '0;
    to_sr        = '0;
    sr_we        = 1'b0;
    du_dsr       = '0;
    lsu_addr     = '0;
    pc_we        = 1'b0;
    spr_wr       = '0;
    icpu_ack     = 1'b1;          // handler fetch answers at once
    icpu_err     = 1'b0;
    repeat (2) @(posedge clk);
    #10;
    rst = 1'b0;

    #5;
    check_value("flushpipe_o", {31'h0, flushpipe}, 32'h0);
    check_value("except_start_o", {31'h0, except_start}, 32'h0);
    check_value("except_type_o", {28'h0, except_type}, 32'h0);
    check_value("epcr_o", epcr, 32'h0);
    check_value("eear_o", eear, 32'h0);
    check_value("esr_o", {16'h0, esr}, 32'h0000_8001);
    report_test("reset values");

    next_cycle();
    data = $random(seed);
    spr_wr.data    = data;
    spr_wr.epcr_we = 1'b1;
    next_cycle();
    spr_wr = '0;
    check_value("epcr_o", epcr, data);
    data = $random(seed);
    spr_wr.data    = data;
    spr_wr.eear_we = 1'b1;
    next_cycle();
    spr_wr   = '0;
    exp_eear = data;
    check_value("eear_o", eear, data);
    data = $random(seed);
    spr_wr.data   = data;
    spr_wr.esr_we = 1'b1;
    next_cycle();
    spr_wr = '0;
    check_value("esr_o", {16'h0, esr}, {16'h0, 1'b1, data[14:0]}); // bit 15 forced
    report_test("spr writes");

    for (i = 0; i < 10; i++)
    begin
      repeat (3) next_cycle();    // refill decode and execute
      r  = $random(seed);
      r2 = $random(seed);
      faults           = '0;
      faults.align     = r[0];
      faults.dtlbmiss  = r[1];
      faults.dmmufault = r[2];
      faults.dbuserr   = r[3];
      faults.range     = r[4];
      syscall  = r[5] | (r[4:0] == 5'h0); // at least one request
      lsu_addr = r2;
      sr       = r[31:16];
      to_sr    = r2[31:16];
      sr_we    = r[6];
      if (r[0])
        exp_type = EXC_ALIGN;
      else if (r[1])
        exp_type = EXC_DTLB;
      else if (r[2])
        exp_type = EXC_DPF;
      else if (r[3])
        exp_type = EXC_BUSERR;
      else if (r[4])
        exp_type = EXC_RANGE;
      else
        exp_type = EXC_SYSCALL;
      data_fault = |r[3:0];
      exp_epcr   = data_fault ? mdl_ex : mdl_id; // range and syscall restart at decode
      if (data_fault)
        exp_eear = r2;
      exp_esr = sr_we ? to_sr : sr;
      #5;
      check_value("flushpipe_o", {31'h0, flushpipe}, 32'h1);
      next_cycle();
      faults  = '0;
      syscall = 1'b0;
      sr_we   = 1'b0;
      check_value("except_type_o", {28'h0, except_type}, {28'h0, exp_type});
      check_value("epcr_o", epcr, exp_epcr);
      check_value("eear_o", eear, exp_eear);
      check_value("esr_o", {16'h0, esr}, {16'h0, exp_esr});
      check_value("extend_flush_o", {31'h0, extend_flush}, 32'h1);
      wait_idle(10);
    end
    report_test("priority and capture");

    next_cycle();
    faults.illegal = 1'b1;
    expect_debug_stop(14'h0040, 12'h080);
    faults.range = 1'b1;
    expect_debug_stop(14'h0400, 12'h004);
    faults.dtlbmiss = 1'b1;
    expect_debug_stop(14'h0100, 12'h020);
    trap = 1'b1;
    expect_debug_stop(14'h2000, 12'h002);
    report_test("debug stop");

    trap = 1'b1;
    next_cycle();
    trap = 1'b0;
    check_value("except_type_o", {28'h0, except_type}, {28'h0, EXC_TRAP});
    n = 0;                        // edges after the fetch acknowledge
    while (extend_flush && n < 10)
    begin
      next_cycle();
      n++;
    end
    trap_cycles = n;
    check_count++;
    assert (n <= 3)
    else
    begin
      $display("trap flush lasted %0d cycles after the fetch acknowledge", n);
      error_count++;
    end
    check_value("except_type_o", {28'h0, except_type}, {28'h0, EXC_NONE});
    repeat (2) next_cycle();
    if_stall       = 1'b1;        // keeps the restart waiting
    faults.illegal = 1'b1;
    #5;
    check_value("abort_ex_o", {31'h0, abort_ex}, 32'h1);
    next_cycle();
    faults = '0;
    check_value("except_type_o", {28'h0, except_type}, {28'h0, EXC_ILLEGAL});
    check_value("except_start_o", {31'h0, except_start}, 32'h1);
    check_value("except_started_o", {31'h0, except_started}, 32'h1);
    n = 0;
    while (extend_flush && n < 10)
    begin
      next_cycle();
      n++;
    end
    check_count++;
    assert (n > trap_cycles)
    else
    begin
      $display("illegal flush ended after %0d cycles, no later than the trap", n);
      error_count++;
    end
    check_value("except_started_o", {31'h0, except_started}, 32'h0); // vector held past the flush
    repeat (3)
    begin
      check_value("except_type_o", {28'h0, except_type}, {28'h0, EXC_ILLEGAL});
      next_cycle();
    end
    if_stall = 1'b0;
    next_cycle();
    check_value("except_type_o", {28'h0, except_type}, {28'h0, EXC_NONE});
    report_test("trap and illegal flush");

    sr      = '0;
    int_req = 1'b1;
    repeat (3) next_cycle();      // delay line empties while the pipe refills
    sr = 16'h0004;                // iee newly set
    #5;
    check_value("flushpipe_o", {31'h0, flushpipe}, 32'h0);
    next_cycle();
    #5;
    check_value("flushpipe_o", {31'h0, flushpipe}, 32'h0);
    n = 0;
    while (!flushpipe && n < 5)
    begin
      next_cycle();
      #5;
      n++;
    end
    check_count++;
    assert (flushpipe)
    else
    begin
      $display("interrupt with iee set never started a flush");
      error_count++;
    end
    exp_epcr = mdl_id;            // interrupt restarts at decode
    next_cycle();
    int_req = 1'b0;
    check_value("except_type_o", {28'h0, except_type}, {28'h0, EXC_INT});
    check_value("epcr_o", epcr, exp_epcr);
    wait_idle(10);
    report_test("interrupt enable delay");

    total_errors = error_count + UUT.u_checker.fail_count;
    $display("tests %0d, checks %0d, tb errors %0d, checker errors %0d", test_count,
             check_count, error_count, UUT.u_checker.fail_count);
    if (total_errors == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

  initial
  begin
    #(WATCHDOG);
    $display("watchdog expired before all tests completed");
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+logic
logic/except_pkg.sv
logic/except_pc_pipe.sv
logic/except_detect.sv
logic/except_select.sv
logic/except_ctrl.sv
logic/except_top.sv
tests/except_checker.sv
tests/except_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile the exception unit testbench with Verilator, run it and scan the log
rm -f sim.log
verilator --binary --timing --assert --top-module except_tb -f project.f \
    -Mdir obj_dir -o except_sim \
  && ./obj_dir/except_sim +verilator+error+limit+1000 > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0
